// ==== hw/apu_pkg.sv ====
package apu_pkg;

	// host side bus fields
	typedef logic [7:0] adr_t; // register offset
	typedef logic [7:0] data_t; // bus data byte

	// master control registers
	localparam adr_t REG_NR50 = 8'h24; // side volumes, cart bits
	localparam adr_t REG_NR51 = 8'h25; // channel routing
	localparam adr_t REG_NR52 = 8'h26; // power, channel status

	// length registers of channels 1 to 4 follow this one
	localparam adr_t REG_LEN_BASE = 8'h30;

	localparam int NUM_CH = 4;
	localparam int LEN_SEL_W = $clog2(NUM_CH); // length channel select

	// one channel's DAC input
	typedef logic [3:0] sample_t;

	// 4 x 15 summed, times a gain of up to 8, gives 480
	typedef logic [8:0] mix_t;

	// per side master volume
	typedef logic [2:0] vol_t;

	// length counter value
	typedef logic [7:0] len_t;

endpackage

// ==== hw/wb_if.sv ====
`timescale 1ns/1ns

interface wb_if;

	logic cyc; // cycle in progress
	logic stb; // transfer request
	logic we; // write when high
	apu_pkg::adr_t adr;
	apu_pkg::data_t dat_w;
	apu_pkg::data_t dat_r;
	logic ack; // one cycle pulse

	modport master(
		output cyc, stb, we, adr, dat_w,
		input dat_r, ack
	);

	modport slave(
		input cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter(
		input logic clk_4mhz,
		input logic reset,
		wb_if.slave m0,
		wb_if.slave m1,
		wb_if.master s
	);

	logic busy; // a master owns the bus
	logic gnt; // owner, 0 = m0, 1 = m1
	logic last; // previous winner
	logic req0, req1;
	logic pick; // winner if granted now
	logic gnt_cyc; // owner still in its cycle

	assign req0 = m0.cyc & m0.stb;
	assign req1 = m1.cyc & m1.stb;

	// on a tie the one that did not win last time goes first
	assign pick = (req0 & req1) ? ~last : req1;

	assign gnt_cyc = gnt ? m1.cyc : m0.cyc;

	always_ff @(posedge clk_4mhz) begin
		if (reset) begin
			busy <= 1'b0;
			gnt  <= 1'b0;
			last <= 1'b1; // m0 wins the first tie
		end else if (!busy) begin
			if (req0 | req1) begin
				busy <= 1'b1;
				gnt  <= pick;
				last <= pick;
			end
		end else if (!gnt_cyc) begin
			busy <= 1'b0; // owner ended its cycle
		end
	end

	always_comb begin
		s.cyc   = busy & gnt_cyc;
		s.stb   = busy & (gnt ? m1.stb : m0.stb);
		s.we    = gnt ? m1.we : m0.we;
		s.adr   = gnt ? m1.adr : m0.adr;
		s.dat_w = gnt ? m1.dat_w : m0.dat_w;

		// only the owner sees the response
		m0.ack   = busy & ~gnt & s.ack;
		m1.ack   = busy & gnt & s.ack;
		m0.dat_r = (busy & ~gnt) ? s.dat_r : '0;
		m1.dat_r = (busy & gnt) ? s.dat_r : '0;
	end

endmodule

// ==== hw/apu_control.sv ====
`timescale 1ns/1ns

module apu_control(
		input logic clk_4mhz,
		input logic reset,
		wb_if.slave bus,
		input logic [apu_pkg::NUM_CH-1:0] active,
		input apu_pkg::len_t len_count,
		output logic len_we,
		output logic [apu_pkg::LEN_SEL_W-1:0] len_sel,
		output apu_pkg::len_t len_data,
		output logic power,
		output apu_pkg::data_t nr50,
		output apu_pkg::data_t nr51
	);

	logic ack_q;
	apu_pkg::data_t dat_r_q;
	apu_pkg::data_t rd_data;
	logic access; // new transfer this cycle
	logic wr;
	logic sel_nr50, sel_nr51, sel_nr52, sel_len;
	logic pwr_clear; // NR52 write with bit 7 low

	assign access = bus.cyc & bus.stb & ~ack_q;
	assign wr     = access & bus.we;

	assign sel_nr50 = bus.adr == apu_pkg::REG_NR50;
	assign sel_nr51 = bus.adr == apu_pkg::REG_NR51;
	assign sel_nr52 = bus.adr == apu_pkg::REG_NR52;
	assign sel_len  = bus.adr[7:2] == apu_pkg::REG_LEN_BASE[7:2]; // 0x30..0x33

	assign pwr_clear = wr & sel_nr52 & ~bus.dat_w[7];

	// length writes go straight through, counters load on the ack edge
	assign len_we   = wr & sel_len;
	assign len_sel  = bus.adr[apu_pkg::LEN_SEL_W-1:0];
	assign len_data = bus.dat_w;

	always_comb begin
		rd_data = 8'hff; // unmapped offsets
		if (sel_nr50)
			rd_data = nr50;
		else if (sel_nr51)
			rd_data = nr51;
		else if (sel_nr52)
			rd_data = {power, 3'b111, active};
		else if (sel_len)
			rd_data = len_count;
	end

	always_ff @(posedge clk_4mhz) begin
		if (reset) begin
			power <= 1'b0;
			nr50  <= '0;
			nr51  <= '0;
		end else begin
			if (wr && sel_nr52)
				power <= bus.dat_w[7];

			// mixer registers are dead while powered down
			if (!power || pwr_clear) begin
				nr50 <= '0;
				nr51 <= '0;
			end else if (wr && sel_nr50) begin
				nr50 <= bus.dat_w;
			end else if (wr && sel_nr51) begin
				nr51 <= bus.dat_w;
			end
		end
	end

	always_ff @(posedge clk_4mhz) begin
		if (reset) begin
			ack_q   <= 1'b0;
			dat_r_q <= '0;
		end else begin
			ack_q <= access; // every cycle is acked
			if (access && !bus.we)
				dat_r_q <= rd_data;
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = dat_r_q;

endmodule

// ==== hw/length_counters.sv ====
`timescale 1ns/1ns

module length_counters(
		input logic clk_4mhz,
		input logic reset,
		input logic power,
		input logic len_tick,
		input logic len_we,
		input logic [apu_pkg::LEN_SEL_W-1:0] len_sel,
		input apu_pkg::len_t len_data,
		output apu_pkg::len_t len_count,
		output logic [apu_pkg::NUM_CH-1:0] active
	);

	apu_pkg::len_t count [apu_pkg::NUM_CH];
	logic [apu_pkg::NUM_CH-1:0] act_q;

	always_ff @(posedge clk_4mhz) begin
		for (int i = 0; i < apu_pkg::NUM_CH; i++) begin
			if (reset || !power) begin
				count[i] <= '0; // held clear while off
				act_q[i] <= 1'b0;
			end else if (len_we && len_sel == i[apu_pkg::LEN_SEL_W-1:0]) begin
				count[i] <= len_data;
				act_q[i] <= |len_data; // zero length stays idle
			end else if (len_tick && act_q[i]) begin
				count[i] <= count[i] - 8'd1;
				if (count[i] == 8'd1)
					act_q[i] <= 1'b0; // ran out
			end
		end
	end

	// read back of the channel the bus points at
	assign len_count = count[len_sel];
	assign active    = act_q;

endmodule

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ns

module frame_sequencer #(
		parameter int DIV_LOG2 = 14
	)(
		input logic clk_4mhz,
		input logic reset,
		input logic power,
		output logic len_tick
	);

	logic [DIV_LOG2-1:0] div_cnt;

	always_ff @(posedge clk_4mhz) begin
		if (reset || !power) begin
			div_cnt  <= '0; // restart phase on power up
			len_tick <= 1'b0;
		end else begin
			div_cnt  <= div_cnt + 1'b1;
			len_tick <= &div_cnt; // wraps on this edge
		end
	end

endmodule

// ==== hw/apu_mixer.sv ====
`timescale 1ns/1ns

module apu_mixer(
		input logic clk_4mhz,
		input logic reset,
		input logic power,
		input apu_pkg::data_t nr50,
		input apu_pkg::data_t nr51,
		input apu_pkg::sample_t ch1_sample,
		input apu_pkg::sample_t ch2_sample,
		input apu_pkg::sample_t ch3_sample,
		input apu_pkg::sample_t ch4_sample,
		output apu_pkg::mix_t left,
		output apu_pkg::mix_t right
	);

	localparam int SUM_W = 6; // four samples of up to 15

	apu_pkg::sample_t smp [apu_pkg::NUM_CH];
	logic [SUM_W-1:0] l_sum, r_sum;
	apu_pkg::vol_t l_vol, r_vol;
	apu_pkg::mix_t l_mix, r_mix;

	assign smp[0] = ch1_sample;
	assign smp[1] = ch2_sample;
	assign smp[2] = ch3_sample;
	assign smp[3] = ch4_sample;

	// NR51 high nibble routes to left, low nibble to right
	always_comb begin
		l_sum = '0;
		r_sum = '0;
		for (int i = 0; i < apu_pkg::NUM_CH; i++) begin
			if (nr51[apu_pkg::NUM_CH+i])
				l_sum = l_sum + {2'b00, smp[i]};
			if (nr51[i])
				r_sum = r_sum + {2'b00, smp[i]};
		end
	end

	assign l_vol = nr50[6:4];
	assign r_vol = nr50[2:0];

	// gain is volume + 1, so a volume of 0 still passes sound
	assign l_mix = apu_pkg::mix_t'(l_sum) * (apu_pkg::mix_t'(l_vol) + 9'd1);
	assign r_mix = apu_pkg::mix_t'(r_sum) * (apu_pkg::mix_t'(r_vol) + 9'd1);

	always_ff @(posedge clk_4mhz) begin
		if (reset || !power) begin
			left  <= '0;
			right <= '0;
		end else begin
			left  <= l_mix;
			right <= r_mix;
		end
	end

endmodule

// ==== hw/apu_top.sv ====
`timescale 1ns/1ns

module apu_top #(
		parameter int DIV_LOG2 = 14
	)(
		input logic clk_4mhz,
		input logic reset,

		input logic host_cyc,
		input logic host_stb,
		input logic host_we,
		input apu_pkg::adr_t host_adr,
		input apu_pkg::data_t host_dat_w,
		output apu_pkg::data_t host_dat_r,
		output logic host_ack,

		input logic dbg_cyc,
		input logic dbg_stb,
		input logic dbg_we,
		input apu_pkg::adr_t dbg_adr,
		input apu_pkg::data_t dbg_dat_w,
		output apu_pkg::data_t dbg_dat_r,
		output logic dbg_ack,

		input apu_pkg::sample_t ch1_sample,
		input apu_pkg::sample_t ch2_sample,
		input apu_pkg::sample_t ch3_sample,
		input apu_pkg::sample_t ch4_sample,
		output apu_pkg::mix_t left,
		output apu_pkg::mix_t right
	);

	wb_if host_bus();
	wb_if dbg_bus();
	wb_if reg_bus(); // arbiter to register block

	logic len_we, len_tick, power;
	logic [apu_pkg::LEN_SEL_W-1:0] len_sel;
	apu_pkg::len_t len_data, len_count;
	logic [apu_pkg::NUM_CH-1:0] active;
	apu_pkg::data_t nr50, nr51;

	assign host_bus.cyc   = host_cyc;
	assign host_bus.stb   = host_stb;
	assign host_bus.we    = host_we;
	assign host_bus.adr   = host_adr;
	assign host_bus.dat_w = host_dat_w;
	assign host_dat_r     = host_bus.dat_r;
	assign host_ack       = host_bus.ack;

	assign dbg_bus.cyc   = dbg_cyc;
	assign dbg_bus.stb   = dbg_stb;
	assign dbg_bus.we    = dbg_we;
	assign dbg_bus.adr   = dbg_adr;
	assign dbg_bus.dat_w = dbg_dat_w;
	assign dbg_dat_r     = dbg_bus.dat_r;
	assign dbg_ack       = dbg_bus.ack;

	wb_arbiter arb_i(
		.clk_4mhz(clk_4mhz), .reset(reset),
		.m0(host_bus.slave), .m1(dbg_bus.slave), .s(reg_bus.master)
	);

	apu_control ctrl_i(
		.clk_4mhz(clk_4mhz), .reset(reset), .bus(reg_bus.slave),
		.active(active), .len_count(len_count),
		.len_we(len_we), .len_sel(len_sel), .len_data(len_data),
		.power(power), .nr50(nr50), .nr51(nr51)
	);

	length_counters len_i(
		.clk_4mhz(clk_4mhz), .reset(reset), .power(power), .len_tick(len_tick),
		.len_we(len_we), .len_sel(len_sel), .len_data(len_data),
		.len_count(len_count), .active(active)
	);

	frame_sequencer #(.DIV_LOG2(DIV_LOG2)) seq_i(
		.clk_4mhz(clk_4mhz), .reset(reset), .power(power), .len_tick(len_tick)
	);

	apu_mixer mix_i(
		.clk_4mhz(clk_4mhz), .reset(reset), .power(power),
		.nr50(nr50), .nr51(nr51),
		.ch1_sample(ch1_sample), .ch2_sample(ch2_sample),
		.ch3_sample(ch3_sample), .ch4_sample(ch4_sample),
		.left(left), .right(right)
	);

endmodule

// ==== dv/apu_tb.sv ====
`timescale 1ns/1ns

module apu_tb;

	localparam int DIV_LOG2 = 4;
	// about 400 transfers of 3 to 6 cycles plus the 4096 cycle length drain, doubled
	localparam int MAX_CYCLES = 20000;

	logic clk_4mhz;
	logic reset;
	logic host_cyc, host_stb, host_we, host_ack;
	apu_pkg::adr_t host_adr;
	apu_pkg::data_t host_dat_w, host_dat_r;
	logic dbg_cyc, dbg_stb, dbg_we, dbg_ack;
	apu_pkg::adr_t dbg_adr;
	apu_pkg::data_t dbg_dat_w, dbg_dat_r;
	apu_pkg::sample_t smp [apu_pkg::NUM_CH];
	apu_pkg::mix_t left, right;

	integer seed = 50430;
	int cycles = 0;
	int acks [2] = '{0, 0}; // index 0 = host, 1 = debug
	int exp_acks [2] = '{0, 0};

	// register model
	logic m_power;
	apu_pkg::data_t m_nr50, m_nr51;
	logic [apu_pkg::NUM_CH-1:0] m_active;
	apu_pkg::len_t m_len [apu_pkg::NUM_CH]; // upper bound while counting

	apu_top #(.DIV_LOG2(DIV_LOG2)) dut_i(
		.clk_4mhz(clk_4mhz), .reset(reset),
		.host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we),
		.host_adr(host_adr), .host_dat_w(host_dat_w), .host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.dbg_cyc(dbg_cyc), .dbg_stb(dbg_stb), .dbg_we(dbg_we),
		.dbg_adr(dbg_adr), .dbg_dat_w(dbg_dat_w), .dbg_dat_r(dbg_dat_r),
		.dbg_ack(dbg_ack),
		.ch1_sample(smp[0]), .ch2_sample(smp[1]),
		.ch3_sample(smp[2]), .ch4_sample(smp[3]),
		.left(left), .right(right)
	);

	initial begin
		clk_4mhz = 1'b0;
		forever #2 clk_4mhz = ~clk_4mhz;
	end

	always @(posedge clk_4mhz) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			fail_run($sformatf("timeout after %0d cycles, the tests did not finish", MAX_CYCLES));
	end

	// acks are stable at the falling edge
	always @(negedge clk_4mhz) begin
		if (host_ack)
			acks[0]++;
		if (dbg_ack)
			acks[1]++;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_data(input string what, input apu_pkg::data_t got,
			input apu_pkg::data_t exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t ns: %s gave 0x%02h, expected 0x%02h",
				$time, what, got, exp));
	endtask

	task automatic check_mix(input string what, input apu_pkg::mix_t got,
			input apu_pkg::mix_t exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t ns: %s output is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_acks();
		if (acks[0] != exp_acks[0] || acks[1] != exp_acks[1])
			fail_run($sformatf("error at %0t ns: acks host %0d of %0d, debug %0d of %0d",
				$time, acks[0], exp_acks[0], acks[1], exp_acks[1]));
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic apu_pkg::data_t rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic bit rand_port();
		return rand_below(2) == 1;
	endfunction

	function automatic bit is_len(input apu_pkg::adr_t a);
		return a >= apu_pkg::REG_LEN_BASE && a < apu_pkg::REG_LEN_BASE + apu_pkg::NUM_CH;
	endfunction

	function automatic apu_pkg::adr_t len_adr(input int ch);
		return apu_pkg::adr_t'(int'(apu_pkg::REG_LEN_BASE) + ch);
	endfunction

	function automatic apu_pkg::adr_t rand_unmapped();
		apu_pkg::adr_t a;
		a = rand_byte();
		while ((a >= apu_pkg::REG_NR50 && a <= apu_pkg::REG_NR52) || is_len(a))
			a = rand_byte();
		return a;
	endfunction

	function automatic apu_pkg::adr_t pick_reg(input int k);
		if (k == 0)
			return apu_pkg::REG_NR50;
		if (k == 1)
			return apu_pkg::REG_NR51;
		return rand_unmapped();
	endfunction

	function automatic void model_write(input apu_pkg::adr_t adr, input apu_pkg::data_t d);
		if (adr == apu_pkg::REG_NR52) begin
			m_power = d[7];
			if (!d[7]) begin // power off wipes everything
				m_nr50 = '0;
				m_nr51 = '0;
				m_active = '0;
				for (int i = 0; i < apu_pkg::NUM_CH; i++)
					m_len[i] = '0;
			end
		end else if (m_power) begin
			if (adr == apu_pkg::REG_NR50)
				m_nr50 = d;
			else if (adr == apu_pkg::REG_NR51)
				m_nr51 = d;
			else if (is_len(adr)) begin
				m_len[adr[1:0]] = d;
				m_active[adr[1:0]] = |d;
			end
		end
	endfunction

	function automatic apu_pkg::data_t expect_read(input apu_pkg::adr_t adr);
		if (adr == apu_pkg::REG_NR50)
			return m_nr50;
		if (adr == apu_pkg::REG_NR51)
			return m_nr51;
		if (adr == apu_pkg::REG_NR52)
			return {m_power, 3'b111, m_active};
		if (is_len(adr))
			return m_len[adr[1:0]];
		return 8'hff;
	endfunction

	// route bit 0 is channel 1
	function automatic apu_pkg::mix_t mix_expect(input logic [3:0] route,
			input apu_pkg::vol_t vol);
		int sum;
		sum = 0;
		for (int i = 0; i < apu_pkg::NUM_CH; i++)
			if (route[i])
				sum += int'(smp[i]);
		sum = m_power ? sum * (int'(vol) + 1) : 0;
		return sum[8:0];
	endfunction

	task automatic drive_port(input bit port, input bit req, input bit we,
			input apu_pkg::adr_t adr, input apu_pkg::data_t d);
		if (port) begin
			dbg_cyc = req;
			dbg_stb = req;
			dbg_we = we;
			dbg_adr = adr;
			dbg_dat_w = d;
		end else begin
			host_cyc = req;
			host_stb = req;
			host_we = we;
			host_adr = adr;
			host_dat_w = d;
		end
	endtask

	// called and returns 1 ns after a rising edge
	task automatic bus_access(input bit port, input bit we, input apu_pkg::adr_t adr,
			input apu_pkg::data_t wdata, output apu_pkg::data_t rdata);
		bit done;
		done = 1'b0;
		exp_acks[port]++;
		drive_port(port, 1'b1, we, adr, wdata);
		while (!done) begin
			@(posedge clk_4mhz);
			#1;
			if (port ? dbg_ack : host_ack) begin
				rdata = port ? dbg_dat_r : host_dat_r;
				done = 1'b1;
			end
		end
		drive_port(port, 1'b0, 1'b0, '0, '0);
		@(posedge clk_4mhz); // one idle cycle frees the arbiter
		#1;
	endtask

	task automatic write_reg(input bit port, input apu_pkg::adr_t adr, input apu_pkg::data_t d);
		apu_pkg::data_t unused;
		bus_access(port, 1'b1, adr, d, unused);
		model_write(adr, d);
	endtask

	task automatic read_reg(input bit port, input apu_pkg::adr_t adr,
			output apu_pkg::data_t got);
		bus_access(port, 1'b0, adr, '0, got);
	endtask

	task automatic read_check(input bit port, input apu_pkg::adr_t adr,
			input apu_pkg::data_t exp);
		apu_pkg::data_t got;
		read_reg(port, adr, got);
		check_data($sformatf("%s read of 0x%02h", port ? "debug" : "host", adr), got, exp);
	endtask

	task automatic check_outputs();
		check_mix("left", left, mix_expect(m_nr51[7:4], m_nr50[6:4]));
		check_mix("right", right, mix_expect(m_nr51[3:0], m_nr50[2:0]));
	endtask

	task automatic after_reset_reads();
		read_check(rand_port(), apu_pkg::REG_NR50, 8'h00);
		read_check(rand_port(), apu_pkg::REG_NR51, 8'h00);
		read_check(rand_port(), apu_pkg::REG_NR52, 8'h70);
		for (int i = 0; i < apu_pkg::NUM_CH; i++)
			read_check(rand_port(), len_adr(i), 8'h00);
		check_mix("left", left, '0);
		check_mix("right", right, '0);
	endtask

	task automatic random_register_access();
		apu_pkg::adr_t adr;
		bit port;
		write_reg(rand_port(), apu_pkg::REG_NR52, 8'h80);
		read_check(rand_port(), apu_pkg::REG_NR52, expect_read(apu_pkg::REG_NR52));
		repeat (150) begin
			port = rand_port();
			adr = pick_reg(rand_below(3));
			if (rand_port())
				write_reg(port, adr, rand_byte());
			else
				read_check(port, adr, expect_read(adr));
		end
	endtask

	task automatic contention_rounds();
		apu_pkg::adr_t adr [2];
		apu_pkg::data_t wdat [2];
		apu_pkg::data_t rdat [2];
		bit we [2];
		int k;
		repeat (60) begin
			k = rand_below(3);
			adr[0] = pick_reg(k);
			adr[1] = pick_reg((k + 1 + rand_below(2)) % 3); // never the same register
			for (int p = 0; p < 2; p++) begin
				we[p] = rand_port();
				wdat[p] = rand_byte();
			end
			fork
				bus_access(1'b0, we[0], adr[0], wdat[0], rdat[0]);
				bus_access(1'b1, we[1], adr[1], wdat[1], rdat[1]);
			join
			for (int p = 0; p < 2; p++) begin
				if (we[p])
					model_write(adr[p], wdat[p]);
				else
					check_data($sformatf("port %0d contended read of 0x%02h", p, adr[p]),
						rdat[p], expect_read(adr[p]));
			end
			check_acks();
		end
	endtask

	task automatic length_drain();
		apu_pkg::data_t r;
		apu_pkg::data_t got;
		logic [3:0] mask;
		r = rand_byte();
		mask = r[3:0];
		// 8 or more ticks, so nothing expires before the status read
		for (int i = 0; i < apu_pkg::NUM_CH; i++)
			write_reg(rand_port(), len_adr(i),
				mask[i] ? apu_pkg::len_t'(8 + rand_below(248)) : 8'h00);
		read_check(rand_port(), apu_pkg::REG_NR52, expect_read(apu_pkg::REG_NR52));
		repeat (6) begin
			for (int i = 0; i < apu_pkg::NUM_CH; i++) begin
				read_reg(rand_port(), len_adr(i), got);
				if (got > m_len[i])
					fail_run($sformatf("error at %0t ns: length %0d rose from %0d to %0d",
						$time, i + 1, m_len[i], got));
				m_len[i] = got;
			end
			repeat (rand_below(64) + 1) @(posedge clk_4mhz);
			#1;
		end
		repeat (256 * 16) @(posedge clk_4mhz); // longest length at one tick per 16
		#1;
		m_active = '0;
		for (int i = 0; i < apu_pkg::NUM_CH; i++) begin
			m_len[i] = '0;
			read_check(rand_port(), len_adr(i), 8'h00);
		end
		read_check(rand_port(), apu_pkg::REG_NR52, expect_read(apu_pkg::REG_NR52));
	endtask

	task automatic mixer_sweep();
		repeat (30) begin
			write_reg(rand_port(), apu_pkg::REG_NR50, rand_byte());
			write_reg(rand_port(), apu_pkg::REG_NR51, rand_byte());
			repeat (2) begin
				for (int i = 0; i < apu_pkg::NUM_CH; i++)
					smp[i] = apu_pkg::sample_t'(rand_below(16));
				repeat (2) @(posedge clk_4mhz);
				#1;
				check_outputs();
			end
		end
		// full scale, 480 on both sides
		write_reg(rand_port(), apu_pkg::REG_NR50, 8'h77);
		write_reg(rand_port(), apu_pkg::REG_NR51, 8'hff);
		for (int i = 0; i < apu_pkg::NUM_CH; i++)
			smp[i] = 4'hf;
		repeat (2) @(posedge clk_4mhz);
		#1;
		check_outputs();
	endtask

	task automatic power_off_clear();
		for (int i = 0; i < apu_pkg::NUM_CH; i++)
			write_reg(rand_port(), len_adr(i), 8'd200);
		write_reg(rand_port(), apu_pkg::REG_NR50, rand_byte() | 8'h11);
		write_reg(rand_port(), apu_pkg::REG_NR52, 8'h00);
		read_check(rand_port(), apu_pkg::REG_NR50, expect_read(apu_pkg::REG_NR50));
		read_check(rand_port(), apu_pkg::REG_NR51, expect_read(apu_pkg::REG_NR51));
		read_check(rand_port(), apu_pkg::REG_NR52, expect_read(apu_pkg::REG_NR52));
		for (int i = 0; i < apu_pkg::NUM_CH; i++)
			read_check(rand_port(), len_adr(i), expect_read(len_adr(i)));
		repeat (2) @(posedge clk_4mhz);
		#1;
		check_outputs();
		write_reg(rand_port(), apu_pkg::REG_NR50, 8'h55); // ignored while off
		read_check(rand_port(), apu_pkg::REG_NR50, expect_read(apu_pkg::REG_NR50));
		write_reg(rand_port(), apu_pkg::REG_NR52, 8'h80);
		write_reg(rand_port(), apu_pkg::REG_NR50, 8'h55);
		read_check(rand_port(), apu_pkg::REG_NR50, expect_read(apu_pkg::REG_NR50));
	endtask

	initial begin
		reset = 1'b1;
		drive_port(1'b0, 1'b0, 1'b0, '0, '0);
		drive_port(1'b1, 1'b0, 1'b0, '0, '0);
		for (int i = 0; i < apu_pkg::NUM_CH; i++)
			smp[i] = '0;
		model_write(apu_pkg::REG_NR52, 8'h00); // model starts powered down
		repeat (8) @(posedge clk_4mhz);
		#1;
		reset = 1'b0;
		after_reset_reads();
		random_register_access();
		contention_rounds();
		length_drain();
		mixer_sweep();
		power_off_clear();
		check_acks();
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== src.f ====
hw/apu_pkg.sv
hw/wb_if.sv
hw/wb_arbiter.sv
hw/apu_control.sv
hw/length_counters.sv
hw/frame_sequencer.sv
hw/apu_mixer.sv
hw/apu_top.sv
dv/apu_tb.sv

// ==== run.sh ====
#!/bin/bash
# build the apu testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module apu_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vapu_tb > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q 'All tests passed!' "$log"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
